/* build.f */
cpu_pkg.sv
regfile.sv
instr_fetch.sv
instr_exec.sv
bus_arbiter.sv
cpu_top.sv
bus_arbiter_sva.sv
tb_cpu_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	--top-module tb_cpu_top \
	-f build.f

./obj_dir/Vtb_cpu_top | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
	exit 0
else
	exit 1
fi

/* tb_cpu_top.sv */
`timescale 1ns/1ps

module tb_cpu_top;

localparam int prog_rows = 39;
localparam int wb_rows   = 26;
localparam int mem_rows  = 3;
localparam int mem_words = 1024;

logic        clk;
logic        rst;
logic        mem_read;
logic        mem_write;
logic [31:0] mem_addr;
logic [31:0] mem_wdata;
logic        mem_stall;
logic [31:0] mem_rddata;
logic        wb_we;
logic [4:0]  wb_addr;
logic [31:0] wb_data;

logic [31:0]    mem [mem_words];
logic [31:0]    prog [prog_rows];
cpu_pkg::op_t   exp_op [wb_rows];
logic [4:0]     exp_reg [wb_rows];
logic [31:0]    exp_val [wb_rows];
int             chk_idx [mem_rows];
logic [31:0]    chk_val [mem_rows];

integer      seed = 32'hd9a9_7561;
int          n_prog;
int          n_wb;
int          wb_seen;
int          wb_errors;
int          mem_errors;
logic        rd_pend;
int          rd_idx;

cpu_top DUT (
	.clk,
	.rst,
	.mem_read,
	.mem_write,
	.mem_addr,
	.mem_wdata,
	.mem_stall,
	.mem_rddata,
	.wb_we,
	.wb_addr,
	.wb_data
);

always #10 clk = ~clk;

function automatic logic [31:0] r_type(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
		logic [4:0] rd, logic [4:0] sh);
	return {cpu_pkg::opc_special, rs, rt, rd, sh, funct};
endfunction

function automatic logic [31:0] i_type(logic [5:0] opc, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
	return {opc, rs, rt, imm};
endfunction

task automatic add_instr(logic [31:0] word);
	prog[n_prog] = word;
	n_prog++;
endtask

task automatic add_wb(cpu_pkg::op_t op, logic [4:0] r, logic [31:0] v);
	exp_op[n_wb]  = op;
	exp_reg[n_wb] = r;
	exp_val[n_wb] = v;
	n_wb++;
endtask

// memory request is taken at the falling edge where it is stable
always @(negedge clk) begin
	rd_pend = 1'b0;
	if (!rst && !mem_stall) begin
		if (mem_write)
			mem[mem_addr[11:2]] = mem_wdata;
		else if (mem_read) begin
			rd_pend = 1'b1;
			rd_idx  = int'(mem_addr[11:2]);
		end
	end
end

always @(posedge clk) begin
	#1;
	mem_rddata = rd_pend ? mem[rd_idx] : 32'h0;
	mem_stall  = ((($random(seed)) & 32'h7fff_ffff) % 100) < 30;
end

initial begin
	repeat (prog_rows * 200) @(posedge clk);
	$display("timeout: write-backs did not complete, %0d of %0d seen", wb_seen, n_wb);
	$display("errors: write-back %0d, memory %0d", wb_errors, mem_errors);
	$display("SIMULATION FAILED");
	$finish;
end

initial begin
	clk        = 1'b0;
	rst        = 1'b1;
	mem_stall  = 1'b0;
	mem_rddata = 32'h0;
	n_prog     = 0;
	n_wb       = 0;
	wb_seen    = 0;
	wb_errors  = 0;
	mem_errors = 0;

	// unused words decode as nop
	for (int i = 0; i < mem_words; i++)
		mem[i] = {16'hbad0, 6'd0, i[9:0]};

	// constants and alu
	add_instr(i_type(cpu_pkg::opc_lui, 5'd0, 5'd1, 16'h1234));
	add_wb(cpu_pkg::op_lui, 5'd1, 32'h1234_0000);
	add_instr(i_type(cpu_pkg::opc_ori, 5'd1, 5'd1, 16'h5678));
	add_wb(cpu_pkg::op_ori, 5'd1, 32'h1234_5678);
	add_instr(i_type(cpu_pkg::opc_addiu, 5'd0, 5'd2, 16'hfffd));
	add_wb(cpu_pkg::op_addiu, 5'd2, 32'hffff_fffd);
	add_instr(i_type(cpu_pkg::opc_addiu, 5'd0, 5'd3, 16'h0005));
	add_wb(cpu_pkg::op_addiu, 5'd3, 32'h0000_0005);
	add_instr(r_type(cpu_pkg::fn_addu, 5'd1, 5'd3, 5'd4, 5'd0));
	add_wb(cpu_pkg::op_addu, 5'd4, 32'h1234_567d);
	add_instr(r_type(cpu_pkg::fn_subu, 5'd3, 5'd2, 5'd5, 5'd0));
	add_wb(cpu_pkg::op_subu, 5'd5, 32'h0000_0008);
	add_instr(r_type(cpu_pkg::fn_and, 5'd1, 5'd2, 5'd6, 5'd0));
	add_wb(cpu_pkg::op_and, 5'd6, 32'h1234_5678);
	add_instr(r_type(cpu_pkg::fn_or, 5'd3, 5'd2, 5'd7, 5'd0));
	add_wb(cpu_pkg::op_or, 5'd7, 32'hffff_fffd);
	add_instr(r_type(cpu_pkg::fn_xor, 5'd1, 5'd3, 5'd8, 5'd0));
	add_wb(cpu_pkg::op_xor, 5'd8, 32'h1234_567d);
	add_instr(r_type(cpu_pkg::fn_slt, 5'd2, 5'd3, 5'd9, 5'd0));
	add_wb(cpu_pkg::op_slt, 5'd9, 32'h0000_0001);
	add_instr(r_type(cpu_pkg::fn_sll, 5'd0, 5'd3, 5'd10, 5'd4));
	add_wb(cpu_pkg::op_sll, 5'd10, 32'h0000_0050);
	// write to r0 must leave no trace
	add_instr(r_type(cpu_pkg::fn_addu, 5'd1, 5'd1, 5'd0, 5'd0));
	add_instr(r_type(cpu_pkg::fn_addu, 5'd0, 5'd3, 5'd11, 5'd0));
	add_wb(cpu_pkg::op_addu, 5'd11, 32'h0000_0005);

	// back-to-back loads and stores
	add_instr(i_type(cpu_pkg::opc_addiu, 5'd0, 5'd12, 16'h0100));
	add_wb(cpu_pkg::op_addiu, 5'd12, 32'h0000_0100);
	add_instr(i_type(cpu_pkg::opc_sw, 5'd12, 5'd1, 16'h0000));
	add_instr(i_type(cpu_pkg::opc_sw, 5'd12, 5'd2, 16'h0004));
	add_instr(i_type(cpu_pkg::opc_lw, 5'd12, 5'd13, 16'h0000));
	add_wb(cpu_pkg::op_lw, 5'd13, 32'h1234_5678);
	add_instr(i_type(cpu_pkg::opc_lw, 5'd12, 5'd14, 16'h0004));
	add_wb(cpu_pkg::op_lw, 5'd14, 32'hffff_fffd);
	add_instr(i_type(cpu_pkg::opc_lw, 5'd12, 5'd15, 16'h0000));
	add_wb(cpu_pkg::op_lw, 5'd15, 32'h1234_5678);

	// taken beq and bne run the delay slot and skip the next one
	add_instr(i_type(cpu_pkg::opc_beq, 5'd3, 5'd11, 16'h0002));
	add_instr(i_type(cpu_pkg::opc_addiu, 5'd0, 5'd16, 16'h0001));
	add_wb(cpu_pkg::op_addiu, 5'd16, 32'h0000_0001);
	add_instr(i_type(cpu_pkg::opc_addiu, 5'd0, 5'd17, 16'h0002));
	add_instr(i_type(cpu_pkg::opc_bne, 5'd3, 5'd2, 16'h0002));
	add_instr(i_type(cpu_pkg::opc_addiu, 5'd0, 5'd18, 16'h0003));
	add_wb(cpu_pkg::op_addiu, 5'd18, 32'h0000_0003);
	add_instr(i_type(cpu_pkg::opc_addiu, 5'd0, 5'd17, 16'h0004));
	// not taken, a wrong take would skip r20
	add_instr(i_type(cpu_pkg::opc_beq, 5'd3, 5'd2, 16'h0003));
	add_instr(i_type(cpu_pkg::opc_addiu, 5'd0, 5'd19, 16'h0006));
	add_wb(cpu_pkg::op_addiu, 5'd19, 32'h0000_0006);
	add_instr(i_type(cpu_pkg::opc_bne, 5'd3, 5'd11, 16'h0005));
	add_instr(i_type(cpu_pkg::opc_addiu, 5'd0, 5'd20, 16'h0007));
	add_wb(cpu_pkg::op_addiu, 5'd20, 32'h0000_0007);

	// fffffffe * 80000003 = 80000001_fffffffa
	add_instr(i_type(cpu_pkg::opc_lui, 5'd0, 5'd21, 16'hffff));
	add_wb(cpu_pkg::op_lui, 5'd21, 32'hffff_0000);
	add_instr(i_type(cpu_pkg::opc_ori, 5'd21, 5'd21, 16'hfffe));
	add_wb(cpu_pkg::op_ori, 5'd21, 32'hffff_fffe);
	add_instr(i_type(cpu_pkg::opc_lui, 5'd0, 5'd22, 16'h8000));
	add_wb(cpu_pkg::op_lui, 5'd22, 32'h8000_0000);
	add_instr(i_type(cpu_pkg::opc_ori, 5'd22, 5'd22, 16'h0003));
	add_wb(cpu_pkg::op_ori, 5'd22, 32'h8000_0003);
	add_instr(r_type(cpu_pkg::fn_multu, 5'd21, 5'd22, 5'd0, 5'd0));
	add_instr(r_type(cpu_pkg::fn_mfhi, 5'd0, 5'd0, 5'd23, 5'd0));
	add_wb(cpu_pkg::op_mfhi, 5'd23, 32'h8000_0001);
	add_instr(r_type(cpu_pkg::fn_mflo, 5'd0, 5'd0, 5'd24, 5'd0));
	add_wb(cpu_pkg::op_mflo, 5'd24, 32'hffff_fffa);
	add_instr(i_type(cpu_pkg::opc_sw, 5'd12, 5'd24, 16'h0008));
	// park here
	add_instr(i_type(cpu_pkg::opc_beq, 5'd0, 5'd0, 16'hffff));
	add_instr(32'h0000_0000);

	chk_idx[0] = 64;
	chk_val[0] = 32'h1234_5678;
	chk_idx[1] = 65;
	chk_val[1] = 32'hffff_fffd;
	chk_idx[2] = 66;
	chk_val[2] = 32'hffff_fffa;

	for (int i = 0; i < n_prog; i++)
		mem[int'(cpu_pkg::reset_pc[11:2]) + i] = prog[i];

	repeat (10) @(posedge clk);
	#1;
	rst = 1'b0;

	for (int i = 0; i < n_wb; i++) begin
		@(negedge clk);
		while (!wb_we)
			@(negedge clk);
		assert (wb_addr == exp_reg[i]) else begin
			$display("[FAIL] %0t wb_addr (%s row %0d) expected %0d got %0d", $time,
				exp_op[i].name(), i, exp_reg[i], wb_addr);
			wb_errors++;
		end
		assert (wb_data == exp_val[i]) else begin
			$display("[FAIL] %0t wb_data (%s row %0d) expected %08h got %08h", $time,
				exp_op[i].name(), i, exp_val[i], wb_data);
			wb_errors++;
		end
		wb_seen++;
	end

	// nothing may retire in the parking loop, and the last store lands
	repeat (60) begin
		@(negedge clk);
		assert (!wb_we) else begin
			$display("unexpected write-back to r%0d at %0t after the program end", wb_addr,
				$time);
			wb_errors++;
		end
	end

	for (int i = 0; i < mem_rows; i++) begin
		assert (mem[chk_idx[i]] == chk_val[i]) else begin
			$display("[FAIL] %0t mem[%0d] expected %08h got %08h", $time, chk_idx[i],
				chk_val[i], mem[chk_idx[i]]);
			mem_errors++;
		end
	end

	$display("errors: write-back %0d, memory %0d", wb_errors, mem_errors);
	if (wb_errors + mem_errors == 0)
		$display("SIMULATION PASSED");
	else
		$display("SIMULATION FAILED");
	$finish;
end

endmodule

/* bus_arbiter_sva.sv */
`timescale 1ns/1ps

module bus_arbiter_sva (
	input logic                clk,
	input logic                rst,
	input logic                ibus_read,
	input logic                ibus_stall,
	input logic                ibus_valid,
	input logic                dbus_read,
	input logic                dbus_write,
	input logic                dbus_stall,
	input logic                dbus_valid,
	input logic                mem_read,
	input logic                mem_write,
	input cpu_pkg::bus_owner_t owner
);

assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
	else $error("mem_read and mem_write high together");

assert property (@(posedge clk) disable iff (rst) !(ibus_valid && dbus_valid))
	else $error("ibus_valid and dbus_valid high together");

// valid only after an accepted request of the same side
assert property (@(posedge clk) disable iff (rst)
	ibus_valid |-> $past(ibus_read && !ibus_stall))
	else $error("ibus_valid without accepted fetch");

assert property (@(posedge clk) disable iff (rst)
	dbus_valid |-> $past((dbus_read || dbus_write) && !dbus_stall))
	else $error("dbus_valid without accepted data request");

assert property (@(posedge clk) rst |=> (!mem_write && !ibus_valid && !dbus_valid &&
	owner == cpu_pkg::own_none))
	else $error("arbiter not idle after reset");

endmodule

bind bus_arbiter bus_arbiter_sva sva_inst (.*);

/* cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
	input  logic        clk,
	input  logic        rst,
	output logic        mem_read,
	output logic        mem_write,
	output logic [31:0] mem_addr,
	output logic [31:0] mem_wdata,
	input  logic        mem_stall,
	input  logic [31:0] mem_rddata,
	output logic        wb_we,
	output logic [4:0]  wb_addr,
	output logic [31:0] wb_data
);

// instruction bus
logic        ibus_read, ibus_stall, ibus_valid;
logic [31:0] ibus_addr, ibus_rddata;

// data bus
logic        dbus_read, dbus_write, dbus_stall, dbus_valid;
logic [31:0] dbus_addr, dbus_wdata, dbus_rddata;

// fetch to exec
logic        instr_valid, instr_take, redirect;
logic [31:0] instr, instr_pc, redirect_pc;

// register file port
logic [4:0]  raddr_a, raddr_b, waddr;
logic [31:0] rdata_a, rdata_b, wdata;
logic        we;

assign wb_we   = we;
assign wb_addr = waddr;
assign wb_data = wdata;

instr_fetch instr_fetch_inst (
	.clk,
	.rst,
	.ibus_read,
	.ibus_addr,
	.ibus_stall,
	.ibus_valid,
	.ibus_rddata,
	.redirect,
	.redirect_pc,
	.instr_take,
	.instr_valid,
	.instr,
	.instr_pc
);

instr_exec instr_exec_inst (
	.clk,
	.rst,
	.instr_valid,
	.instr,
	.instr_pc,
	.instr_take,
	.redirect,
	.redirect_pc,
	.raddr_a,
	.raddr_b,
	.rdata_a,
	.rdata_b,
	.we,
	.waddr,
	.wdata,
	.dbus_read,
	.dbus_write,
	.dbus_addr,
	.dbus_wdata,
	.dbus_stall,
	.dbus_valid,
	.dbus_rddata
);

regfile regfile_inst (
	.clk,
	.rst,
	.raddr_a,
	.raddr_b,
	.rdata_a,
	.rdata_b,
	.we,
	.waddr,
	.wdata
);

bus_arbiter bus_arbiter_inst (
	.clk,
	.rst,
	.ibus_read,
	.ibus_addr,
	.ibus_stall,
	.ibus_valid,
	.ibus_rddata,
	.dbus_read,
	.dbus_write,
	.dbus_addr,
	.dbus_wdata,
	.dbus_stall,
	.dbus_valid,
	.dbus_rddata,
	.mem_read,
	.mem_write,
	.mem_addr,
	.mem_wdata,
	.mem_stall,
	.mem_rddata
);

endmodule

/* bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
	input  logic        clk,
	input  logic        rst,
	input  logic        ibus_read,
	input  logic [31:0] ibus_addr,
	output logic        ibus_stall,
	output logic        ibus_valid,
	output logic [31:0] ibus_rddata,
	input  logic        dbus_read,
	input  logic        dbus_write,
	input  logic [31:0] dbus_addr,
	input  logic [31:0] dbus_wdata,
	output logic        dbus_stall,
	output logic        dbus_valid,
	output logic [31:0] dbus_rddata,
	output logic        mem_read,
	output logic        mem_write,
	output logic [31:0] mem_addr,
	output logic [31:0] mem_wdata,
	input  logic        mem_stall,
	input  logic [31:0] mem_rddata
);

cpu_pkg::bus_owner_t owner;
logic data_req, data_grant, instr_grant;

// data side has fixed priority
assign data_req    = dbus_read | dbus_write;
assign data_grant  = data_req;
assign instr_grant = ibus_read & ~data_req;

assign mem_read  = data_grant ? dbus_read : instr_grant;
assign mem_write = data_grant & dbus_write;
assign mem_addr  = data_grant ? dbus_addr : ibus_addr;
assign mem_wdata = dbus_wdata;

assign dbus_stall = mem_stall;
assign ibus_stall = mem_stall | data_req;

// owner of the word coming back next cycle
always_ff @(posedge clk) begin
	if (rst)
		owner <= cpu_pkg::own_none;
	else if (!mem_stall && data_grant)
		owner <= cpu_pkg::own_data;
	else if (!mem_stall && instr_grant)
		owner <= cpu_pkg::own_instr;
	else
		owner <= cpu_pkg::own_none;
end

assign ibus_valid  = (owner == cpu_pkg::own_instr);
assign dbus_valid  = (owner == cpu_pkg::own_data);
assign ibus_rddata = ibus_valid ? mem_rddata : '0;
assign dbus_rddata = dbus_valid ? mem_rddata : '0;

endmodule

/* instr_exec.sv */
`timescale 1ns/1ps

module instr_exec (
	input  logic        clk,
	input  logic        rst,
	input  logic        instr_valid,
	input  logic [31:0] instr,
	input  logic [31:0] instr_pc,
	output logic        instr_take,
	output logic        redirect,
	output logic [31:0] redirect_pc,
	output logic [4:0]  raddr_a,
	output logic [4:0]  raddr_b,
	input  logic [31:0] rdata_a,
	input  logic [31:0] rdata_b,
	output logic        we,
	output logic [4:0]  waddr,
	output logic [31:0] wdata,
	output logic        dbus_read,
	output logic        dbus_write,
	output logic [31:0] dbus_addr,
	output logic [31:0] dbus_wdata,
	input  logic        dbus_stall,
	input  logic        dbus_valid,
	input  logic [31:0] dbus_rddata
);

cpu_pkg::op_t        op;
cpu_pkg::exec_state_t state;

logic [5:0]  opcode, funct;
logic [4:0]  rs, rt, rd, shamt, dest;
logic [31:0] imm_sext, imm_zext, alu_result;
logic [63:0] hilo;
logic        run, is_mem, writes_reg, run_wr, load_done;
logic        mem_pend, mem_load;
logic [4:0]  mem_rt;
logic [31:0] mem_addr_q, mem_wdata_q;

assign opcode   = instr[31:26];
assign rs       = instr[25:21];
assign rt       = instr[20:16];
assign rd       = instr[15:11];
assign shamt    = instr[10:6];
assign funct    = instr[5:0];
assign imm_sext = {{16{instr[15]}}, instr[15:0]};
assign imm_zext = {16'h0000, instr[15:0]};

assign raddr_a = rs;
assign raddr_b = rt;

always_comb begin
	op = cpu_pkg::op_nop;
	case (opcode)
		cpu_pkg::opc_special: begin
			case (funct)
				cpu_pkg::fn_addu:  op = cpu_pkg::op_addu;
				cpu_pkg::fn_subu:  op = cpu_pkg::op_subu;
				cpu_pkg::fn_and:   op = cpu_pkg::op_and;
				cpu_pkg::fn_or:    op = cpu_pkg::op_or;
				cpu_pkg::fn_xor:   op = cpu_pkg::op_xor;
				cpu_pkg::fn_slt:   op = cpu_pkg::op_slt;
				cpu_pkg::fn_sll:   op = cpu_pkg::op_sll;
				cpu_pkg::fn_multu: op = cpu_pkg::op_multu;
				cpu_pkg::fn_mfhi:  op = cpu_pkg::op_mfhi;
				cpu_pkg::fn_mflo:  op = cpu_pkg::op_mflo;
				default:           op = cpu_pkg::op_nop;
			endcase
		end
		cpu_pkg::opc_addiu: op = cpu_pkg::op_addiu;
		cpu_pkg::opc_ori:   op = cpu_pkg::op_ori;
		cpu_pkg::opc_lui:   op = cpu_pkg::op_lui;
		cpu_pkg::opc_lw:    op = cpu_pkg::op_lw;
		cpu_pkg::opc_sw:    op = cpu_pkg::op_sw;
		cpu_pkg::opc_beq:   op = cpu_pkg::op_beq;
		cpu_pkg::opc_bne:   op = cpu_pkg::op_bne;
		default:            op = cpu_pkg::op_nop;
	endcase
end

// result and destination of single-cycle ops
always_comb begin
	alu_result = '0;
	dest       = rd;
	writes_reg = 1'b1;
	case (op)
		cpu_pkg::op_addu:  alu_result = rdata_a + rdata_b;
		cpu_pkg::op_subu:  alu_result = rdata_a - rdata_b;
		cpu_pkg::op_and:   alu_result = rdata_a & rdata_b;
		cpu_pkg::op_or:    alu_result = rdata_a | rdata_b;
		cpu_pkg::op_xor:   alu_result = rdata_a ^ rdata_b;
		cpu_pkg::op_slt:   alu_result = {31'd0, $signed(rdata_a) < $signed(rdata_b)};
		cpu_pkg::op_sll:   alu_result = rdata_b << shamt;
		cpu_pkg::op_mfhi:  alu_result = hilo[63:32];
		cpu_pkg::op_mflo:  alu_result = hilo[31:0];
		cpu_pkg::op_addiu: begin
			alu_result = rdata_a + imm_sext;
			dest       = rt;
		end
		cpu_pkg::op_ori: begin
			alu_result = rdata_a | imm_zext;
			dest       = rt;
		end
		cpu_pkg::op_lui: begin
			alu_result = {instr[15:0], 16'h0000};
			dest       = rt;
		end
		default: writes_reg = 1'b0;
	endcase
end

// every instruction leaves the fetch buffer in the cycle it starts
assign run        = (state == cpu_pkg::ex_run) & instr_valid;
assign instr_take = run;
assign is_mem     = (op == cpu_pkg::op_lw) | (op == cpu_pkg::op_sw);

assign redirect    = run & (((op == cpu_pkg::op_beq) & (rdata_a == rdata_b)) |
	((op == cpu_pkg::op_bne) & (rdata_a != rdata_b)));
assign redirect_pc = instr_pc + 32'd4 + {imm_sext[29:0], 2'b00};

assign run_wr    = run & writes_reg & (dest != 5'd0);
assign load_done = (state == cpu_pkg::ex_mem_wait) & dbus_valid & mem_load & (mem_rt != 5'd0);
assign we        = run_wr | load_done;
assign waddr     = load_done ? mem_rt : dest;
assign wdata     = load_done ? dbus_rddata : alu_result;

assign dbus_read  = mem_pend & mem_load;
assign dbus_write = mem_pend & ~mem_load;
assign dbus_addr  = mem_addr_q;
assign dbus_wdata = mem_wdata_q;

always_ff @(posedge clk) begin
	if (rst) begin
		state    <= cpu_pkg::ex_run;
		mem_pend <= 1'b0;
	end else begin
		case (state)
			cpu_pkg::ex_run: begin
				if (run && is_mem) begin
					state    <= cpu_pkg::ex_mem_wait;
					mem_pend <= 1'b1;
				end
			end
			cpu_pkg::ex_mem_wait: begin
				if (mem_pend && !dbus_stall)
					mem_pend <= 1'b0;
				if (dbus_valid)
					state <= cpu_pkg::ex_run;
			end
			default: state <= cpu_pkg::ex_run;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (run && is_mem) begin
		mem_load    <= (op == cpu_pkg::op_lw);
		mem_rt      <= rt;
		mem_addr_q  <= rdata_a + imm_sext;
		mem_wdata_q <= rdata_b;
	end
	if (run && op == cpu_pkg::op_multu)
		hilo <= {32'd0, rdata_a} * {32'd0, rdata_b};
end

endmodule

/* instr_fetch.sv */
`timescale 1ns/1ps

module instr_fetch (
	input  logic        clk,
	input  logic        rst,
	output logic        ibus_read,
	output logic [31:0] ibus_addr,
	input  logic        ibus_stall,
	input  logic        ibus_valid,
	input  logic [31:0] ibus_rddata,
	input  logic        redirect,
	input  logic [31:0] redirect_pc,
	input  logic        instr_take,
	output logic        instr_valid,
	output logic [31:0] instr,
	output logic [31:0] instr_pc
);

logic [31:0] pc, req_pc, redir_target;
logic [31:0] buf_instr, buf_pc;
logic        buf_valid, outstanding, stale, redir_pend;
logic        accept, fill, slot_issued;
logic [31:0] delay_pc;

// one request at a time, and only if its data has somewhere to land
assign ibus_read = ~outstanding & (~buf_valid | instr_take);
assign ibus_addr = pc;
assign accept    = ibus_read & ~ibus_stall;
assign fill      = ibus_valid & ~stale;

// the branch sits in the buffer when redirect pulses
assign delay_pc    = instr_pc + 32'd4;
assign slot_issued = (outstanding && req_pc == delay_pc) || (accept && pc == delay_pc);

always_ff @(posedge clk) begin
	if (rst) begin
		pc          <= cpu_pkg::reset_pc;
		buf_valid   <= 1'b0;
		outstanding <= 1'b0;
		stale       <= 1'b0;
		redir_pend  <= 1'b0;
	end else begin
		if (accept)
			outstanding <= 1'b1;
		else if (ibus_valid)
			outstanding <= 1'b0;

		if (ibus_valid)
			stale <= 1'b0;
		if (redirect && ((outstanding && req_pc != delay_pc) || (accept && pc != delay_pc)))
			stale <= 1'b1;

		if (fill)
			buf_valid <= 1'b1;
		else if (instr_take)
			buf_valid <= 1'b0;

		if (redirect) begin
			if (slot_issued) begin
				pc <= redirect_pc;
			end else begin
				// delay slot still to fetch, target comes after it
				pc         <= delay_pc;
				redir_pend <= 1'b1;
			end
		end else if (accept) begin
			pc         <= redir_pend ? redir_target : pc + 32'd4;
			redir_pend <= 1'b0;
		end
	end
end

always_ff @(posedge clk) begin
	if (accept)
		req_pc <= pc;
	if (redirect)
		redir_target <= redirect_pc;
	if (fill) begin
		buf_instr <= ibus_rddata;
		buf_pc    <= req_pc;
	end
end

assign instr_valid = buf_valid;
assign instr       = buf_instr;
assign instr_pc    = buf_pc;

endmodule

/* regfile.sv */
`timescale 1ns/1ps

module regfile (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  raddr_a,
	input  logic [4:0]  raddr_b,
	output logic [31:0] rdata_a,
	output logic [31:0] rdata_b,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata
);

logic [31:0] regs [cpu_pkg::reg_num];

always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < cpu_pkg::reg_num; i++) begin
			regs[i] <= '0;
		end
	end else if (we && waddr != 5'd0) begin
		// r0 never leaves zero
		regs[waddr] <= wdata;
	end
end

assign rdata_a = regs[raddr_a];
assign rdata_b = regs[raddr_b];

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

// first fetch address after reset
localparam logic [31:0] reset_pc = 32'h0000_0000;
localparam int reg_num = 32;

typedef enum logic [4:0] {
	op_addu,
	op_subu,
	op_and,
	op_or,
	op_xor,
	op_slt,
	op_sll,
	op_addiu,
	op_ori,
	op_lui,
	op_lw,
	op_sw,
	op_beq,
	op_bne,
	op_multu,
	op_mfhi,
	op_mflo,
	op_nop
} op_t;

typedef enum logic {
	ex_run,
	ex_mem_wait
} exec_state_t;

// whose read or write is outstanding on the memory port
typedef enum logic [1:0] {
	own_none,
	own_instr,
	own_data
} bus_owner_t;

// primary opcodes
localparam logic [5:0] opc_special = 6'h00;
localparam logic [5:0] opc_beq     = 6'h04;
localparam logic [5:0] opc_bne     = 6'h05;
localparam logic [5:0] opc_addiu   = 6'h09;
localparam logic [5:0] opc_ori     = 6'h0d;
localparam logic [5:0] opc_lui     = 6'h0f;
localparam logic [5:0] opc_lw      = 6'h23;
localparam logic [5:0] opc_sw      = 6'h2b;

// funct codes under special
localparam logic [5:0] fn_sll   = 6'h00;
localparam logic [5:0] fn_mfhi  = 6'h10;
localparam logic [5:0] fn_mflo  = 6'h12;
localparam logic [5:0] fn_multu = 6'h19;
localparam logic [5:0] fn_addu  = 6'h21;
localparam logic [5:0] fn_subu  = 6'h23;
localparam logic [5:0] fn_and   = 6'h24;
localparam logic [5:0] fn_or    = 6'h25;
localparam logic [5:0] fn_xor   = 6'h26;
localparam logic [5:0] fn_slt   = 6'h2a;

endpackage
